/* hw/ahbLitePkg.sv */
package ahbLitePkg;

    // Bus encodings ------------------------
    typedef enum logic [1:0] {
        idle   = 2'b00,
        busy   = 2'b01,
        nonSeq = 2'b10,
        seq    = 2'b11
    } hTransE;

    typedef enum logic [2:0] {
        sizeByte = 3'b000,
        sizeHalf = 3'b001,
        sizeWord = 3'b010
    } hSizeE;

    typedef enum logic [1:0] {
        slaveRam     = 2'd0,
        slaveGpio    = 2'd1,
        slaveTimer   = 2'd2,
        slaveDefault = 2'd3                         // Must stay the top position
    } slaveIdE;

    // Memory map ---------------------------
    localparam int slaveCount   = 4;
    localparam int ramAddrWidth = 10;               // 1 KB, 256 words
    localparam int windowBits   = 12;               // 4 KB peripheral window
    localparam int gpioWidth    = 32;

    localparam logic [31:0] ramBase   = 32'h0000_0000;
    localparam logic [31:0] gpioBase  = 32'h4000_0000;
    localparam logic [31:0] timerBase = 32'h4000_1000;

    localparam logic [windowBits-1:0] gpioOutOfs     = 12'h000;
    localparam logic [windowBits-1:0] gpioDirOfs     = 12'h004;
    localparam logic [windowBits-1:0] gpioInOfs      = 12'h008;
    localparam logic [windowBits-1:0] timerLoadOfs   = 12'h000;
    localparam logic [windowBits-1:0] timerCtrlOfs   = 12'h004;
    localparam logic [windowBits-1:0] timerValueOfs  = 12'h008;
    localparam logic [windowBits-1:0] timerStatusOfs = 12'h00C;

    // Helpers shared by the slaves ---------
    function automatic logic isActive(hTransE trans);
        return (trans == nonSeq) || (trans == seq);  // Busy and idle carry no data
    endfunction

    function automatic logic [3:0] byteLanes(hSizeE size, logic [1:0] addrLow);
        logic [3:0] lanes;
        case (size)
            sizeByte: lanes = 4'b0001 << addrLow;
            sizeHalf: lanes = addrLow[1] ? 4'b1100 : 4'b0011;
            default:  lanes = 4'b1111;
        endcase
        return lanes;
    endfunction

    function automatic logic [31:0] laneMask(logic [3:0] lanes);
        logic [31:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[i*8 +: 8] = {8{lanes[i]}};         // Byte enable to bit mask
        end
        return mask;
    endfunction

endpackage

/* hw/ahbLiteDecoder.sv */
`timescale 1ns/1ps

module ahbLiteDecoder (
    input  logic [31:0]                      hAddr,
    output logic [ahbLitePkg::slaveCount-1:0] hSel
);
    import ahbLitePkg::*;

    logic ramHit;                                           // Inside the 1 KB RAM only
    logic gpioHit;
    logic timerHit;

    // Region compares ----------------------
    assign ramHit   = (hAddr[31:ramAddrWidth] == ramBase[31:ramAddrWidth]);
    assign gpioHit  = (hAddr[31:windowBits] == gpioBase[31:windowBits]);
    assign timerHit = (hAddr[31:windowBits] == timerBase[31:windowBits]);

    // Regions are disjoint, default takes the rest
    assign hSel[slaveRam]     = ramHit;
    assign hSel[slaveGpio]    = gpioHit;
    assign hSel[slaveTimer]   = timerHit;
    assign hSel[slaveDefault] = !(ramHit || gpioHit || timerHit);   // Holes and RAM beyond 1 KB

endmodule

/* hw/ahbLiteSlaveMux.sv */
`timescale 1ns/1ps

module ahbLiteSlaveMux (
    input  logic                                     HCLK,
    input  logic                                     rst,
    input  logic                                     hReady,
    input  logic [ahbLitePkg::slaveCount-1:0]        hSel,
    input  ahbLitePkg::hTransE                       hTrans,
    input  logic [ahbLitePkg::slaveCount-2:0]        hReadyOutVec,  // Bus slaves only
    input  logic [ahbLitePkg::slaveCount-2:0]        hRespVec,
    input  logic [(ahbLitePkg::slaveCount-1)*32-1:0] hRDataVec,
    output logic                                     hReadyOut,
    output logic                                     hResp,
    output logic [31:0]                              hRData
);
    import ahbLitePkg::*;

    typedef enum logic {okay, errorSecond} defStateE;

    slaveIdE                selIdx;                 // Address phase owner
    slaveIdE                dataSel;                // Data phase owner
    logic                   dataPhase;
    logic                   defPhase;
    defStateE               defState;
    logic                   defReady;
    logic                   defResp;
    logic [slaveCount-1:0]  readyAll;
    logic [slaveCount-1:0]  respAll;
    logic [slaveCount*32-1:0] rDataAll;

    always_comb begin
        selIdx = slaveDefault;
        for (int i = 0; i < slaveCount; i++) begin
            if (hSel[i]) begin
                selIdx = slaveIdE'(i);              // One-hot to index
            end
        end
    end

    // Data phase tracking ------------------
    always_ff @(posedge HCLK) begin
        if (rst) begin
            dataPhase <= 1'b0;
            dataSel   <= slaveRam;
        end else if (hReady) begin
            dataPhase <= isActive(hTrans);
            if (isActive(hTrans)) begin
                dataSel <= selIdx;
            end
        end
    end

    // Default slave, two-cycle ERROR -------
    assign defPhase = dataPhase && (dataSel == slaveDefault);
    assign defReady = !(defPhase && defState == okay);      // Low in first error cycle
    assign defResp  = defPhase;

    always_ff @(posedge HCLK) begin
        if (rst) begin
            defState <= okay;
        end else if (defState == errorSecond) begin
            defState <= okay;
        end else if (defPhase) begin
            defState <= errorSecond;
        end
    end

    // Response routing, default on top
    assign readyAll = {defReady, hReadyOutVec};
    assign respAll  = {defResp, hRespVec};
    assign rDataAll = {32'h0000_0000, hRDataVec};

    assign hReadyOut = readyAll[dataSel];
    assign hResp     = respAll[dataSel];
    assign hRData    = rDataAll[dataSel*32 +: 32];

endmodule

/* hw/ahbLiteBlockRam.sv */
`timescale 1ns/1ps

module ahbLiteBlockRam #(
    parameter int addrWidth = ahbLitePkg::ramAddrWidth     // Byte address bits
) (
    input  logic               HCLK,
    input  logic               rst,
    input  logic               hSel,
    input  logic [31:0]        hAddr,
    input  ahbLitePkg::hTransE hTrans,
    input  logic               hWrite,
    input  ahbLitePkg::hSizeE  hSize,
    input  logic [31:0]        hWData,
    input  logic               hReady,
    output logic [31:0]        hRData,
    output logic               hReadyOut,
    output logic               hResp
);
    import ahbLitePkg::*;

    localparam int wordBits  = addrWidth - 2;
    localparam int wordCount = 2 ** wordBits;

    logic [31:0]         mem [wordCount];
    logic                accept;
    logic                wrPending;                 // Write data phase in flight
    logic [wordBits-1:0] wordAddr;
    logic [3:0]          laneEn;

    assign accept = hSel && hReady && isActive(hTrans);

    // Address phase capture ----------------
    always_ff @(posedge HCLK) begin
        if (rst) begin
            wrPending <= 1'b0;
        end else if (hReady) begin
            wrPending <= accept && hWrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            wordAddr <= hAddr[addrWidth-1:2];
            laneEn   <= byteLanes(hSize, hAddr[1:0]);   // Lanes from size and offset
        end
    end

    // Data phase write ---------------------
    always_ff @(posedge HCLK) begin
        if (wrPending && hReady) begin
            for (int i = 0; i < 4; i++) begin
                if (laneEn[i]) begin
                    mem[wordAddr][i*8 +: 8] <= hWData[i*8 +: 8];
                end
            end
        end
    end

    // Async read from captured word, sees last write
    assign hRData = mem[wordAddr];

    assign hReadyOut = 1'b1;                        // Zero wait
    assign hResp     = 1'b0;                        // Always OKAY

endmodule

/* hw/ahbLiteGpio.sv */
`timescale 1ns/1ps

module ahbLiteGpio (
    input  logic                             HCLK,
    input  logic                             rst,
    input  logic                             hSel,
    input  logic [31:0]                      hAddr,
    input  ahbLitePkg::hTransE               hTrans,
    input  logic                             hWrite,
    input  ahbLitePkg::hSizeE                hSize,
    input  logic [31:0]                      hWData,
    input  logic                             hReady,
    output logic [31:0]                      hRData,
    output logic                             hReadyOut,
    output logic                             hResp,
    input  logic [ahbLitePkg::gpioWidth-1:0] gpioIn,
    output logic [ahbLitePkg::gpioWidth-1:0] gpioOut,
    output logic [ahbLitePkg::gpioWidth-1:0] gpioOe
);
    import ahbLitePkg::*;

    logic                    accept;
    logic                    wrPending;
    logic [windowBits-1:2]   regAddr;               // Word offset in window
    logic [3:0]              laneEn;
    logic [31:0]             wMask;
    logic [gpioWidth-1:0]    dataOut;
    logic [gpioWidth-1:0]    direction;             // 1 drives the pin
    logic [gpioWidth-1:0]    syncStage;
    logic [gpioWidth-1:0]    dataIn;

    assign accept = hSel && hReady && isActive(hTrans);
    assign wMask  = laneMask(laneEn);

    // Address phase capture ----------------
    always_ff @(posedge HCLK) begin
        if (rst) begin
            wrPending <= 1'b0;
        end else if (hReady) begin
            wrPending <= accept && hWrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            regAddr <= hAddr[windowBits-1:2];
            laneEn  <= byteLanes(hSize, hAddr[1:0]);
        end
    end

    // Registers, dataIn offset ignored on write
    always_ff @(posedge HCLK) begin
        if (rst) begin
            dataOut   <= '0;
            direction <= '0;                        // All inputs out of reset
        end else if (wrPending && hReady) begin
            if (regAddr == gpioOutOfs[windowBits-1:2]) begin
                dataOut <= (dataOut & ~wMask[gpioWidth-1:0])
                         | (hWData[gpioWidth-1:0] & wMask[gpioWidth-1:0]);
            end
            if (regAddr == gpioDirOfs[windowBits-1:2]) begin
                direction <= (direction & ~wMask[gpioWidth-1:0])
                           | (hWData[gpioWidth-1:0] & wMask[gpioWidth-1:0]);
            end
        end
    end

    // Two-flop input synchronizer ----------
    always_ff @(posedge HCLK) begin
        syncStage <= gpioIn;
        dataIn    <= syncStage;
    end

    always_comb begin
        case (regAddr)
            gpioOutOfs[windowBits-1:2]: hRData = 32'(dataOut);
            gpioDirOfs[windowBits-1:2]: hRData = 32'(direction);
            gpioInOfs[windowBits-1:2]:  hRData = 32'(dataIn);
            default:                    hRData = 32'h0000_0000;
        endcase
    end

    assign gpioOut   = dataOut;                     // Pad logic applies gpioOe
    assign gpioOe    = direction;
    assign hReadyOut = 1'b1;
    assign hResp     = 1'b0;

endmodule

/* hw/ahbLiteTimer.sv */
`timescale 1ns/1ps

module ahbLiteTimer (
    input  logic               HCLK,
    input  logic               rst,
    input  logic               hSel,
    input  logic [31:0]        hAddr,
    input  ahbLitePkg::hTransE hTrans,
    input  logic               hWrite,
    input  ahbLitePkg::hSizeE  hSize,
    input  logic [31:0]        hWData,
    input  logic               hReady,
    output logic [31:0]        hRData,
    output logic               hReadyOut,
    output logic               hResp,
    output logic               irq
);
    import ahbLitePkg::*;

    logic                  accept;
    logic                  wrPending;
    logic                  regWrite;
    logic [windowBits-1:2] regAddr;
    logic [3:0]            laneEn;
    logic [31:0]           wMask;
    logic [31:0]           loadReg;
    logic [31:0]           loadNext;                // Load after lane merge
    logic [31:0]           counter;
    logic                  enable;
    logic                  irqEnable;
    logic                  pending;

    assign accept   = hSel && hReady && isActive(hTrans);
    assign regWrite = wrPending && hReady;
    assign wMask    = laneMask(laneEn);
    assign loadNext = (loadReg & ~wMask) | (hWData & wMask);

    // Address phase capture ----------------
    always_ff @(posedge HCLK) begin
        if (rst) begin
            wrPending <= 1'b0;
        end else if (hReady) begin
            wrPending <= accept && hWrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            regAddr <= hAddr[windowBits-1:2];
            laneEn  <= byteLanes(hSize, hAddr[1:0]);
        end
    end

    // Counter and control ------------------
    always_ff @(posedge HCLK) begin
        if (rst) begin
            loadReg   <= '0;
            counter   <= '0;
            enable    <= 1'b0;
            irqEnable <= 1'b0;
            pending   <= 1'b0;
        end else begin
            if (regWrite && regAddr == timerCtrlOfs[windowBits-1:2]) begin
                if (wMask[0]) begin
                    enable    <= hWData[0];
                    irqEnable <= hWData[1];
                end
            end
            if (regWrite && regAddr == timerStatusOfs[windowBits-1:2] && wMask[0] && hWData[0]) begin
                pending <= 1'b0;                    // W1C, a same-edge reload wins
            end
            if (regWrite && regAddr == timerLoadOfs[windowBits-1:2]) begin
                loadReg <= loadNext;
                counter <= loadNext;                // Restart period
            end else if (enable) begin
                if (counter == 32'd0) begin
                    counter <= loadReg;             // Period is load plus 1
                    pending <= 1'b1;
                end else begin
                    counter <= counter - 32'd1;
                end
            end
        end
    end

    always_comb begin
        case (regAddr)
            timerLoadOfs[windowBits-1:2]:   hRData = loadReg;
            timerCtrlOfs[windowBits-1:2]:   hRData = {30'd0, irqEnable, enable};
            timerValueOfs[windowBits-1:2]:  hRData = counter;
            timerStatusOfs[windowBits-1:2]: hRData = {31'd0, pending};
            default:                        hRData = 32'h0000_0000;
        endcase
    end

    assign irq       = pending && irqEnable;
    assign hReadyOut = 1'b1;
    assign hResp     = 1'b0;

endmodule

/* hw/ahbLiteSubsystem.sv */
`timescale 1ns/1ps

module ahbLiteSubsystem (
    input  logic                             HCLK,
    input  logic                             rst,
    input  logic [31:0]                      hAddr,
    input  ahbLitePkg::hTransE               hTrans,
    input  logic                             hWrite,
    input  ahbLitePkg::hSizeE                hSize,
    input  logic [31:0]                      hWData,
    input  logic [ahbLitePkg::gpioWidth-1:0] gpioIn,
    output logic                             hReady,
    output logic [31:0]                      hRData,
    output logic                             hResp,
    output logic [ahbLitePkg::gpioWidth-1:0] gpioOut,
    output logic [ahbLitePkg::gpioWidth-1:0] gpioOe,
    output logic                             irq
);
    import ahbLitePkg::*;

    logic [slaveCount-1:0]        hSel;             // One-hot select
    logic [slaveCount-2:0]        hReadyOutVec;     // Default slave lives in the mux
    logic [slaveCount-2:0]        hRespVec;
    logic [(slaveCount-1)*32-1:0] hRDataVec;

    // Decode and response mux --------------
    ahbLiteDecoder i_decoder (.hAddr(hAddr), .hSel(hSel));

    ahbLiteSlaveMux i_slaveMux (
        .HCLK(HCLK), .rst(rst), .hReady(hReady), .hSel(hSel), .hTrans(hTrans),
        .hReadyOutVec(hReadyOutVec), .hRespVec(hRespVec), .hRDataVec(hRDataVec),
        .hReadyOut(hReady), .hResp(hResp), .hRData(hRData)
    );

    // Slaves -------------------------------
    ahbLiteBlockRam i_ram (
        .HCLK(HCLK), .rst(rst), .hSel(hSel[slaveRam]), .hAddr(hAddr), .hTrans(hTrans),
        .hWrite(hWrite), .hSize(hSize), .hWData(hWData), .hReady(hReady),
        .hRData(hRDataVec[slaveRam*32 +: 32]), .hReadyOut(hReadyOutVec[slaveRam]),
        .hResp(hRespVec[slaveRam])
    );

    ahbLiteGpio i_gpio (
        .HCLK(HCLK), .rst(rst), .hSel(hSel[slaveGpio]), .hAddr(hAddr), .hTrans(hTrans),
        .hWrite(hWrite), .hSize(hSize), .hWData(hWData), .hReady(hReady),
        .hRData(hRDataVec[slaveGpio*32 +: 32]), .hReadyOut(hReadyOutVec[slaveGpio]),
        .hResp(hRespVec[slaveGpio]),
        .gpioIn(gpioIn), .gpioOut(gpioOut), .gpioOe(gpioOe)
    );

    ahbLiteTimer i_timer (
        .HCLK(HCLK), .rst(rst), .hSel(hSel[slaveTimer]), .hAddr(hAddr), .hTrans(hTrans),
        .hWrite(hWrite), .hSize(hSize), .hWData(hWData), .hReady(hReady),
        .hRData(hRDataVec[slaveTimer*32 +: 32]), .hReadyOut(hReadyOutVec[slaveTimer]),
        .hResp(hRespVec[slaveTimer]),
        .irq(irq)
    );

endmodule

/* testbench/ahbLiteSubsystem_checker.sv */
`timescale 1ns/1ps

module ahbLiteSubsystemChecker (
    input logic                              HCLK,
    input logic                              rst,
    input logic [ahbLitePkg::slaveCount-1:0] hSel,
    input logic                              hReady,
    input logic                              hResp,
    input logic                              irq
);
    int assertFails = 0;                            // Picked up by the testbench

    // Bus protocol -------------------------
    selOneHot: assert property (@(posedge HCLK) disable iff (rst) $onehot(hSel)) else begin
        $error("hSel is not one-hot");
        assertFails++;
    end

    errorTwoCycle: assert property (@(posedge HCLK) disable iff (rst)
        (hResp && !hReady) |=> (hResp && hReady)) else begin
        $error("ERROR response did not complete in its second cycle");
        assertFails++;
    end

    singleWait: assert property (@(posedge HCLK) disable iff (rst) !hReady |=> hReady) else begin
        $error("hReady low for two cycles in a row");
        assertFails++;
    end

    // Interrupt held off in reset
    irqResetLow: assert property (@(posedge HCLK) (rst && $past(rst)) |-> !irq) else begin
        $error("irq high during reset");
        assertFails++;
    end

endmodule

bind ahbLiteSubsystem ahbLiteSubsystemChecker i_checker (
    .HCLK(HCLK), .rst(rst), .hSel(hSel), .hReady(hReady), .hResp(hResp), .irq(irq)
);

/* testbench/ahbLiteSubsystemTb.sv */
`timescale 1ns/1ps

module ahbLiteSubsystemTb;
    import ahbLitePkg::*;

    typedef struct packed {
        logic        write;
        hSizeE       size;
        logic [31:0] addr;
        logic [31:0] wData;
        logic [31:0] expData;                       // Reads only
        logic        expErr;
    } stimEntryT;

    localparam int tableLen      = 20;
    localparam int randomCount   = 64;
    localparam int maxOps        = 2 * randomCount; // Write plus read per random word
    localparam int timeoutCycles = (tableLen + 2 * randomCount) * 4 + 200;
    localparam int timerLoad     = 10;

    localparam logic [31:0] gpioOutAddr = gpioBase | 32'(gpioOutOfs);
    localparam logic [31:0] gpioDirAddr = gpioBase | 32'(gpioDirOfs);
    localparam logic [31:0] gpioInAddr  = gpioBase | 32'(gpioInOfs);
    localparam logic [31:0] tLoadAddr   = timerBase | 32'(timerLoadOfs);
    localparam logic [31:0] tCtrlAddr   = timerBase | 32'(timerCtrlOfs);
    localparam logic [31:0] tStatAddr   = timerBase | 32'(timerStatusOfs);

    logic        HCLK = 1'b0;
    logic        rst;
    logic [31:0] hAddr;
    hTransE      hTrans;
    logic        hWrite;
    hSizeE       hSize;
    logic [31:0] hWData;
    logic [31:0] gpioIn;
    logic        hReady;
    logic [31:0] hRData;
    logic        hResp;
    logic [31:0] gpioOut;
    logic [31:0] gpioOe;
    logic        irq;

    stimEntryT   stimTable [tableLen];
    logic        opWrite [maxOps];                  // Pipelined transfer list
    hSizeE       opSize [maxOps];
    logic [31:0] opAddr [maxOps];
    logic [31:0] opWData [maxOps];
    logic [31:0] opRData [maxOps];
    logic        opResp [maxOps];
    logic [31:0] randExp [randomCount];
    logic [31:0] shadow [256];                      // Predicted RAM words
    logic [7:0]  written [$];
    logic [7:0]  wordIdx;
    int          pick;
    logic [31:0] lcgState = 32'h1e98_7973;
    int          errorCount = 0;
    int          cycleCount = 0;

    ahbLiteSubsystem i_dut (.*);

    always #50 HCLK = ~HCLK;                        // 100 ns period

    // Run limit ----------------------------
    always @(posedge HCLK) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("Timeout after %0d cycles, transfers did not complete", timeoutCycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic setOp(input int i, input logic write, input hSizeE size,
                         input logic [31:0] addr, input logic [31:0] data);
        opWrite[i] = write;
        opSize[i]  = size;
        opAddr[i]  = addr;
        opWData[i] = data;
    endtask

    task automatic driveOp(input int i);
        if (i < 0) begin
            hTrans = idle;
            hWrite = 1'b0;
        end else begin
            hTrans = nonSeq;
            hAddr  = opAddr[i];
            hWrite = opWrite[i];
            hSize  = opSize[i];
        end
    endtask

    // Back-to-back AHB pipeline over ops 0..count-1
    task automatic runOps(input int count);
        int   addrOp;
        int   dataOp;
        logic ready;
        addrOp = 0;
        dataOp = -1;
        @(negedge HCLK);
        driveOp(0);
        while (addrOp >= 0 || dataOp >= 0) begin
            ready = hReady;                         // Holds until the next rising edge
            if (ready && dataOp >= 0) begin
                opRData[dataOp] = hRData;           // Last data phase cycle
                opResp[dataOp]  = hResp;
            end
            @(negedge HCLK);
            if (ready) begin
                dataOp = addrOp;                    // Accepted address now in data phase
                if (dataOp >= 0) begin
                    hWData = opWData[dataOp];
                end
                addrOp = (addrOp >= 0 && addrOp + 1 < count) ? addrOp + 1 : -1;
                driveOp(addrOp);                    // Held while hReady is low
            end
        end
    endtask

    task automatic busTransfer(input logic write, input logic [31:0] addr, input logic [31:0] data);
        setOp(0, write, sizeWord, addr, data);
        runOps(1);
    endtask

    task automatic readCheck(input logic [31:0] addr, input logic [31:0] exp, input string what);
        busTransfer(1'b0, addr, 32'h0);
        checkValue({what, " response"}, 32'(opResp[0]), 32'h0);
        checkValue(what, opRData[0], exp);
    endtask

    initial begin
        rst    = 1'b1;
        hAddr  = 32'h0;
        hTrans = idle;
        hWrite = 1'b0;
        hSize  = sizeWord;
        hWData = 32'h0;
        gpioIn = 32'h0;
        stimTable = '{
            '{1'b1, sizeWord, 32'h0000_0000, 32'h0BAD_F00D, 32'h0,          1'b0},
            '{1'b1, sizeWord, 32'h0000_0010, 32'h1122_3344, 32'h0,          1'b0},
            '{1'b0, sizeWord, 32'h0000_0010, 32'h0,         32'h1122_3344, 1'b0},
            '{1'b1, sizeHalf, 32'h0000_0012, 32'hAABB_0000, 32'h0,          1'b0},
            '{1'b0, sizeWord, 32'h0000_0010, 32'h0,         32'hAABB_3344, 1'b0},
            '{1'b1, sizeByte, 32'h0000_0011, 32'h0000_CC00, 32'h0,          1'b0},
            '{1'b0, sizeWord, 32'h0000_0010, 32'h0,         32'hAABB_CC44, 1'b0},
            '{1'b1, sizeByte, 32'h0000_0013, 32'hDD00_0000, 32'h0,          1'b0},
            '{1'b1, sizeHalf, 32'h0000_0010, 32'h0000_EEFF, 32'h0,          1'b0},
            '{1'b0, sizeWord, 32'h0000_0010, 32'h0,         32'hDDBB_EEFF, 1'b0},
            '{1'b1, sizeWord, gpioOutAddr,   32'hA5A5_0F0F, 32'h0,          1'b0},
            '{1'b0, sizeWord, gpioOutAddr,   32'h0,         32'hA5A5_0F0F, 1'b0},
            '{1'b1, sizeWord, gpioDirAddr,   32'hFFFF_0000, 32'h0,          1'b0},
            '{1'b0, sizeWord, gpioDirAddr,   32'h0,         32'hFFFF_0000, 1'b0},
            '{1'b0, sizeWord, 32'h5000_0000, 32'h0,         32'h0,          1'b1},
            '{1'b0, sizeWord, 32'h0000_0010, 32'h0,         32'hDDBB_EEFF, 1'b0},
            '{1'b1, sizeWord, 32'h0000_0400, 32'h1234_5678, 32'h0,          1'b1},
            '{1'b0, sizeWord, 32'h0000_0000, 32'h0,         32'h0BAD_F00D, 1'b0},
            '{1'b1, sizeWord, 32'h7FFF_FFF0, 32'h0,         32'h0,          1'b1},
            '{1'b0, sizeWord, gpioOutAddr,   32'h0,         32'hA5A5_0F0F, 1'b0}
        };
        repeat (8) @(negedge HCLK);
        rst = 1'b0;

        // Reset state --------------------------
        checkValue("hReady after reset", 32'(hReady), 32'h1);
        checkValue("hResp after reset", 32'(hResp), 32'h0);
        checkValue("irq after reset", 32'(irq), 32'h0);
        checkValue("gpioOe after reset", gpioOe, 32'h0);

        // Table, RAM lanes, GPIO regs, ERROR ---
        for (int i = 0; i < tableLen; i++) begin
            setOp(i, stimTable[i].write, stimTable[i].size, stimTable[i].addr, stimTable[i].wData);
        end
        runOps(tableLen);                           // ERROR cycles stall the pipe
        for (int i = 0; i < tableLen; i++) begin
            checkValue($sformatf("entry %0d response", i), 32'(opResp[i]),
                       32'(stimTable[i].expErr));
            if (!stimTable[i].write && !stimTable[i].expErr) begin
                checkValue($sformatf("entry %0d data", i), opRData[i], stimTable[i].expData);
            end
        end
        checkValue("gpioOut pins", gpioOut, 32'hA5A5_0F0F);
        checkValue("gpioOe pins", gpioOe, 32'hFFFF_0000);

        // GPIO input path
        gpioIn = 32'h3C3C_5A5A;
        repeat (2) @(negedge HCLK);                 // Two synchronizer edges
        readCheck(gpioInAddr, 32'h3C3C_5A5A, "gpio dataIn");
        busTransfer(1'b1, gpioInAddr, 32'hFFFF_FFFF);  // Read-only register
        readCheck(gpioInAddr, 32'h3C3C_5A5A, "gpio dataIn after write");
        checkValue("gpioOut after dataIn write", gpioOut, 32'hA5A5_0F0F);

        // Timer --------------------------------
        busTransfer(1'b1, tLoadAddr, timerLoad);
        busTransfer(1'b1, tCtrlAddr, 32'h3);        // Enable plus irqEnable
        repeat (timerLoad) @(negedge HCLK);
        checkValue("irq one cycle before period end", 32'(irq), 32'h0);
        @(negedge HCLK);                            // Load plus 1 cycles
        checkValue("irq at period end", 32'(irq), 32'h1);
        readCheck(tStatAddr, 32'h1, "timer status pending");
        busTransfer(1'b1, tStatAddr, 32'h1);        // W1C
        checkValue("irq after status clear", 32'(irq), 32'h0);
        busTransfer(1'b1, tCtrlAddr, 32'h1);        // Count with irq masked
        repeat (timerLoad + 1) @(negedge HCLK);
        checkValue("irq with irqEnable clear", 32'(irq), 32'h0);
        readCheck(tStatAddr, 32'h1, "timer status with irq masked");

        // Random RAM pass, no idle cycles
        for (int i = 0; i < randomCount; i++) begin
            lcgState = lcgNext(lcgState);
            wordIdx  = lcgState[23:16];
            lcgState = lcgNext(lcgState);
            shadow[wordIdx] = lcgState;
            written.push_back(wordIdx);
            setOp(2 * i, 1'b1, sizeWord, {22'd0, wordIdx, 2'b00}, lcgState);
            if (i % 2 == 1) begin
                pick    = int'(lcgState[31:24]) % written.size();
                wordIdx = written[pick];            // Revisit an older word
            end
            randExp[i] = shadow[wordIdx];
            setOp(2 * i + 1, 1'b0, sizeWord, {22'd0, wordIdx, 2'b00}, 32'h0);
        end
        runOps(maxOps);
        for (int i = 0; i < randomCount; i++) begin
            checkValue($sformatf("random read %0d response", i), 32'(opResp[2 * i + 1]), 32'h0);
            checkValue($sformatf("random read %0d data", i), opRData[2 * i + 1], randExp[i]);
        end

        errorCount += i_dut.i_checker.assertFails;
        $display("Errors: %0d, of which %0d from assertions", errorCount,
                 i_dut.i_checker.assertFails);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* ahbLiteSubsystem.f */
hw/ahbLitePkg.sv
hw/ahbLiteDecoder.sv
hw/ahbLiteSlaveMux.sv
hw/ahbLiteBlockRam.sv
hw/ahbLiteGpio.sv
hw/ahbLiteTimer.sv
hw/ahbLiteSubsystem.sv
testbench/ahbLiteSubsystem_checker.sv
testbench/ahbLiteSubsystemTb.sv

/* runSim.sh */
#!/bin/sh
# Compile and run the AHB-Lite subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# Keep running past assertion errors so the testbench reports the result
verilator --binary --timing --assert --top-module ahbLiteSubsystemTb \
    -f ahbLiteSubsystem.f -o simAhbLite \
    && ./obj_dir/simAhbLite +verilator+error+limit+100 > sim.log 2>&1

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
